//--- rtl/rob_pkg.sv
`default_nettype none

package rob_pkg;

    // Operand, result and pc width
    localparam int DATA_W = 32;

    // Destination register index width
    localparam int RD_W = 5;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_XOR,
        OP_SLL,
        OP_MUL,
        OP_ILLEGAL
    } opcode_t;

    typedef enum logic [1:0] {
        CAUSE_NONE,
        CAUSE_ILLEGAL,
        CAUSE_SHIFT
    } cause_t;

    // Result of one lane operation; multiply keeps the low word
    function automatic logic [DATA_W-1:0] lane_result(
        input opcode_t           op,
        input logic [DATA_W-1:0] a,
        input logic [DATA_W-1:0] b
    );
        logic [2*DATA_W-1:0] product;
        product = a * b;
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << b[4:0];
            OP_MUL:  return product[DATA_W-1:0];
            default: return '0;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- rtl/lane_req_if.sv
`timescale 1ns/100ps
`default_nettype none

// Issued operation from dispatch to one execution lane
interface lane_req_if #(
    parameter int TAG_W = 3
) ();

    logic                          valid;
    logic [TAG_W-1:0]              tag;
    rob_pkg::opcode_t              op;
    logic [rob_pkg::DATA_W-1:0]    a;
    logic [rob_pkg::DATA_W-1:0]    b;

    modport src (output valid, output tag, output op, output a, output b);
    modport dst (input valid, input tag, input op, input a, input b);

endinterface

`default_nettype wire

//--- rtl/complete_if.sv
`timescale 1ns/100ps
`default_nettype none

// One lane's completion back to the reorder buffer
interface complete_if #(
    parameter int TAG_W = 3
) ();

    logic                          valid;
    logic [TAG_W-1:0]              tag;
    logic [rob_pkg::DATA_W-1:0]    value;
    rob_pkg::cause_t               cause;

    modport src (output valid, output tag, output value, output cause);
    modport dst (input valid, input tag, input value, input cause);

endinterface

`default_nettype wire

//--- rtl/dispatch_unit.sv
`timescale 1ns/100ps
`default_nettype none

module dispatch_unit #(
    parameter int NUM_LANES = 3,
    parameter int TAG_W     = 3
) (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic                       issue_valid,
    input  wire rob_pkg::opcode_t           issue_op,
    input  wire logic [rob_pkg::DATA_W-1:0] issue_a,
    input  wire logic [rob_pkg::DATA_W-1:0] issue_b,
    input  wire logic                       full,
    input  wire logic                       flush,
    input  wire logic [TAG_W-1:0]           alloc_tag,
    output logic                            alloc,
    lane_req_if.src                         req [NUM_LANES]
);

    localparam int LANE_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    logic [LANE_W-1:0] rr_ptr;

    // Issue is dropped while the buffer is full or flushing
    assign alloc = issue_valid && !full && !flush;

    // Round-robin lane pointer, moves only on accepted issue
    always_ff @(posedge clk) begin
        if (reset) begin
            rr_ptr <= '0;
        end else if (alloc) begin
            if (rr_ptr == LANE_W'(NUM_LANES - 1)) begin
                rr_ptr <= '0;
            end else begin
                rr_ptr <= rr_ptr + 1'b1;
            end
        end
    end

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane_req
        logic sel;

        assign sel = alloc && (rr_ptr == LANE_W'(g));

        always_ff @(posedge clk) begin
            if (reset) begin
                req[g].valid <= 1'b0;
            end else begin
                req[g].valid <= sel;
            end
        end

        // Payload only loads when this lane is picked
        always_ff @(posedge clk) begin
            if (sel) begin
                req[g].tag <= alloc_tag;
                req[g].op  <= issue_op;
                req[g].a   <= issue_a;
                req[g].b   <= issue_b;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/exec_lane.sv
`timescale 1ns/100ps
`default_nettype none

module exec_lane #(
    parameter int LATENCY = 1,
    parameter int TAG_W   = 3
) (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic flush,
    lane_req_if.dst   req,
    complete_if.src   cpl
);

    logic                       stage_valid [LATENCY];
    logic [TAG_W-1:0]           stage_tag   [LATENCY];
    logic [rob_pkg::DATA_W-1:0] stage_value [LATENCY];
    rob_pkg::cause_t            stage_cause [LATENCY];

    logic [rob_pkg::DATA_W-1:0] entry_value;
    rob_pkg::cause_t            entry_cause;

    // Result and exception are settled when the op enters the pipe
    assign entry_value = rob_pkg::lane_result(req.op, req.a, req.b);

    always_comb begin
        entry_cause = rob_pkg::CAUSE_NONE;
        if (req.op == rob_pkg::OP_ILLEGAL) begin
            entry_cause = rob_pkg::CAUSE_ILLEGAL;
        end else if (req.op == rob_pkg::OP_SLL && req.b >= rob_pkg::DATA_W) begin
            entry_cause = rob_pkg::CAUSE_SHIFT;
        end
    end

    // Flush empties every stage, including whatever arrives this cycle
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            for (int i = 0; i < LATENCY; i++) begin
                stage_valid[i] <= 1'b0;
            end
        end else begin
            stage_valid[0] <= req.valid;
            for (int i = 1; i < LATENCY; i++) begin
                stage_valid[i] <= stage_valid[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        stage_tag[0]   <= req.tag;
        stage_value[0] <= entry_value;
        stage_cause[0] <= entry_cause;
        for (int i = 1; i < LATENCY; i++) begin
            stage_tag[i]   <= stage_tag[i-1];
            stage_value[i] <= stage_value[i-1];
            stage_cause[i] <= stage_cause[i-1];
        end
    end

    assign cpl.valid = stage_valid[LATENCY-1];
    assign cpl.tag   = stage_tag[LATENCY-1];
    assign cpl.value = stage_value[LATENCY-1];
    assign cpl.cause = stage_cause[LATENCY-1];

endmodule

`default_nettype wire

//--- rtl/reorder_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module reorder_buffer #(
    parameter int ROB_SIZE  = 8,
    parameter int NUM_LANES = 3,
    parameter int TAG_W     = 3
) (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic                       alloc,
    input  wire logic [rob_pkg::DATA_W-1:0] alloc_pc,
    input  wire logic [rob_pkg::RD_W-1:0]   alloc_rd,
    complete_if.dst                         cpl [NUM_LANES],
    output logic [TAG_W-1:0]                alloc_tag,
    output logic                            full,
    output logic                            commit_valid,
    output logic [rob_pkg::DATA_W-1:0]      commit_pc,
    output logic [rob_pkg::RD_W-1:0]        commit_rd,
    output logic [rob_pkg::DATA_W-1:0]      commit_value,
    output logic                            flush_valid,
    output logic [rob_pkg::DATA_W-1:0]      flush_pc,
    output rob_pkg::cause_t                 flush_cause
);

    localparam int CNT_W = $clog2(ROB_SIZE + 1);

    logic [rob_pkg::DATA_W-1:0] entry_pc    [ROB_SIZE];
    logic [rob_pkg::RD_W-1:0]   entry_rd    [ROB_SIZE];
    logic [rob_pkg::DATA_W-1:0] entry_value [ROB_SIZE];
    rob_pkg::cause_t            entry_cause [ROB_SIZE];
    logic [ROB_SIZE-1:0]        entry_valid;
    logic [ROB_SIZE-1:0]        entry_complete;

    logic [TAG_W-1:0] head;
    logic [TAG_W-1:0] tail;
    logic [CNT_W-1:0] count;

    // Lane completions flattened for loop indexing
    logic                       cpl_valid [NUM_LANES];
    logic [TAG_W-1:0]           cpl_tag   [NUM_LANES];
    logic [rob_pkg::DATA_W-1:0] cpl_value [NUM_LANES];
    rob_pkg::cause_t            cpl_cause [NUM_LANES];

    logic head_done;
    logic retire;
    logic do_flush;

    function automatic logic [TAG_W-1:0] next_ptr(input logic [TAG_W-1:0] ptr);
        if (ptr == TAG_W'(ROB_SIZE - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_cpl
        assign cpl_valid[g] = cpl[g].valid;
        assign cpl_tag[g]   = cpl[g].tag;
        assign cpl_value[g] = cpl[g].value;
        assign cpl_cause[g] = cpl[g].cause;
    end

    assign alloc_tag = tail;
    assign full      = (count == CNT_W'(ROB_SIZE));

    // Head leaves either as a commit or as a flush of everything
    assign head_done = entry_valid[head] && entry_complete[head];
    assign retire    = head_done && (entry_cause[head] == rob_pkg::CAUSE_NONE);
    assign do_flush  = head_done && (entry_cause[head] != rob_pkg::CAUSE_NONE);

    always_ff @(posedge clk) begin
        if (reset || do_flush) begin
            head           <= '0;
            tail           <= '0;
            count          <= '0;
            entry_valid    <= '0;
            entry_complete <= '0;
        end else begin
            // Tags from different lanes never collide
            for (int i = 0; i < NUM_LANES; i++) begin
                if (cpl_valid[i] && entry_valid[cpl_tag[i]]) begin
                    entry_complete[cpl_tag[i]] <= 1'b1;
                end
            end
            if (alloc) begin
                entry_valid[tail]    <= 1'b1;
                entry_complete[tail] <= 1'b0;
                tail                 <= next_ptr(tail);
            end
            if (retire) begin
                entry_valid[head]    <= 1'b0;
                entry_complete[head] <= 1'b0;
                head                 <= next_ptr(head);
            end
            case ({alloc, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            commit_valid <= 1'b0;
            flush_valid  <= 1'b0;
        end else begin
            commit_valid <= retire;
            flush_valid  <= do_flush;
        end
    end

    // Entry payload
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_LANES; i++) begin
            if (cpl_valid[i] && entry_valid[cpl_tag[i]]) begin
                entry_value[cpl_tag[i]] <= cpl_value[i];
                entry_cause[cpl_tag[i]] <= cpl_cause[i];
            end
        end
        if (alloc) begin
            entry_pc[tail] <= alloc_pc;
            entry_rd[tail] <= alloc_rd;
        end
    end

    // Retirement payload, held until the next event
    always_ff @(posedge clk) begin
        if (retire) begin
            commit_pc    <= entry_pc[head];
            commit_rd    <= entry_rd[head];
            commit_value <= entry_value[head];
        end
        if (do_flush) begin
            flush_pc    <= entry_pc[head];
            flush_cause <= entry_cause[head];
        end
    end

endmodule

`default_nettype wire

//--- rtl/rob_subsystem.sv
`timescale 1ns/100ps
`default_nettype none

module rob_subsystem #(
    parameter int ROB_SIZE          = 8,
    parameter int NUM_LANES         = 3,
    parameter int LANE_BASE_LATENCY = 1
) (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic                       issue_valid,
    input  wire logic [rob_pkg::DATA_W-1:0] issue_pc,
    input  wire logic [rob_pkg::RD_W-1:0]   issue_rd,
    input  wire rob_pkg::opcode_t           issue_op,
    input  wire logic [rob_pkg::DATA_W-1:0] issue_a,
    input  wire logic [rob_pkg::DATA_W-1:0] issue_b,
    output logic                            full,
    output logic                            commit_valid,
    output logic [rob_pkg::DATA_W-1:0]      commit_pc,
    output logic [rob_pkg::RD_W-1:0]        commit_rd,
    output logic [rob_pkg::DATA_W-1:0]      commit_value,
    output logic                            flush_valid,
    output logic [rob_pkg::DATA_W-1:0]      flush_pc,
    output rob_pkg::cause_t                 flush_cause
);

    localparam int TAG_W = $clog2(ROB_SIZE);

    logic             alloc;
    logic [TAG_W-1:0] alloc_tag;

    lane_req_if #(.TAG_W(TAG_W)) lane_req [NUM_LANES] ();
    complete_if #(.TAG_W(TAG_W)) lane_cpl [NUM_LANES] ();

    dispatch_unit #(
        .NUM_LANES (NUM_LANES),
        .TAG_W     (TAG_W)
    ) u_dispatch (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_a     (issue_a),
        .issue_b     (issue_b),
        .full        (full),
        .flush       (flush_valid),
        .alloc_tag   (alloc_tag),
        .alloc       (alloc),
        .req         (lane_req)
    );

    // Lane i is one cycle slower than lane i-1
    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        exec_lane #(
            .LATENCY (LANE_BASE_LATENCY + g),
            .TAG_W   (TAG_W)
        ) u_lane (
            .clk   (clk),
            .reset (reset),
            .flush (flush_valid),
            .req   (lane_req[g]),
            .cpl   (lane_cpl[g])
        );
    end

    reorder_buffer #(
        .ROB_SIZE  (ROB_SIZE),
        .NUM_LANES (NUM_LANES),
        .TAG_W     (TAG_W)
    ) u_rob (
        .clk          (clk),
        .reset        (reset),
        .alloc        (alloc),
        .alloc_pc     (issue_pc),
        .alloc_rd     (issue_rd),
        .cpl          (lane_cpl),
        .alloc_tag    (alloc_tag),
        .full         (full),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_rd    (commit_rd),
        .commit_value (commit_value),
        .flush_valid  (flush_valid),
        .flush_pc     (flush_pc),
        .flush_cause  (flush_cause)
    );

endmodule

`default_nettype wire

//--- verif/tb_rob_subsystem.sv
`timescale 1ns/100ps
`default_nettype none

module tb_rob_subsystem;

    localparam int ROB_SIZE          = 8;
    localparam int NUM_LANES         = 3;
    // Slow lanes so that a steady issue stream fills the buffer
    localparam int LANE_BASE_LATENCY = 4;
    localparam int NUM_RANDOM        = 300;
    localparam int NUM_BURST         = 100;
    localparam int NUM_ISSUES        = NUM_RANDOM + NUM_BURST;
    localparam int DRAIN_LIMIT       = ROB_SIZE * (LANE_BASE_LATENCY + NUM_LANES + 2);
    localparam longint WATCHDOG_NS   = 40 * (NUM_ISSUES * (ROB_SIZE + NUM_LANES + 4) + 100);

    typedef struct packed {
        logic [31:0]     pc;
        logic [4:0]      rd;
        logic [31:0]     value;
        rob_pkg::cause_t cause;
    } exp_entry_t;

    logic                 clk = 1'b0;
    logic                 reset;
    logic                 issue_valid;
    logic [31:0]          issue_pc;
    logic [4:0]           issue_rd;
    rob_pkg::opcode_t     issue_op;
    logic [31:0]          issue_a;
    logic [31:0]          issue_b;
    logic                 full;
    logic                 commit_valid;
    logic [31:0]          commit_pc;
    logic [4:0]           commit_rd;
    logic [31:0]          commit_value;
    logic                 flush_valid;
    logic [31:0]          flush_pc;
    rob_pkg::cause_t      flush_cause;

    exp_entry_t expect_q[$];
    logic [31:0] rng_state = 32'h5d87;
    int error_count = 0;
    int commit_count = 0;
    int flush_count = 0;
    int full_cycles = 0;

    rob_subsystem #(
        .ROB_SIZE          (ROB_SIZE),
        .NUM_LANES         (NUM_LANES),
        .LANE_BASE_LATENCY (LANE_BASE_LATENCY)
    ) DUT (
        .clk          (clk),
        .reset        (reset),
        .issue_valid  (issue_valid),
        .issue_pc     (issue_pc),
        .issue_rd     (issue_rd),
        .issue_op     (issue_op),
        .issue_a      (issue_a),
        .issue_b      (issue_b),
        .full         (full),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_rd    (commit_rd),
        .commit_value (commit_value),
        .flush_valid  (flush_valid),
        .flush_pc     (flush_pc),
        .flush_cause  (flush_cause)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Reference arithmetic for one instruction
    function automatic exp_entry_t model_entry(input logic [31:0] pc, input logic [4:0] rd,
                                               input rob_pkg::opcode_t op,
                                               input logic [31:0] a, input logic [31:0] b);
        exp_entry_t  e;
        logic [63:0] wide;
        e.pc    = pc;
        e.rd    = rd;
        e.value = 32'h0;
        e.cause = rob_pkg::CAUSE_NONE;
        wide    = {32'h0, a} * {32'h0, b};
        case (op)
            rob_pkg::OP_ADD: e.value = a + b;
            rob_pkg::OP_SUB: e.value = a + ~b + 32'd1;
            rob_pkg::OP_AND: e.value = a & b;
            rob_pkg::OP_XOR: e.value = (a | b) & ~(a & b);
            rob_pkg::OP_SLL: begin
                if (b > 32'd31) begin
                    e.cause = rob_pkg::CAUSE_SHIFT;
                end else begin
                    e.value = a << b;
                end
            end
            rob_pkg::OP_MUL: e.value = wide[31:0];
            default:         e.cause = rob_pkg::CAUSE_ILLEGAL;
        endcase
        return e;
    endfunction

    task automatic drive_random_issue();
        logic [31:0] r;
        logic [31:0] r_low;
        int          pick;
        r    = next_random();
        pick = int'(r[31:16] % 20);
        if (pick == 0) begin
            issue_op = rob_pkg::OP_ILLEGAL;
        end else begin
            pick     = int'(r[31:16] % 6);
            issue_op = rob_pkg::opcode_t'(pick[2:0]);
        end
        r        = next_random();
        issue_pc = {r[31:2], 2'b00};
        issue_rd = r[31:27];
        r        = next_random();
        r_low    = next_random();
        issue_a  = {r[31:16], r_low[31:16]};
        r        = next_random();
        // Shift amounts mostly in range, sometimes 32 or more
        if (issue_op == rob_pkg::OP_SLL) begin
            issue_b = 32'(r[31:16] % 40);
        end else begin
            r_low   = next_random();
            issue_b = {r[31:16], r_low[31:16]};
        end
        issue_valid = 1'b1;
    endtask

    // Outputs are read before this edge updates them
    always @(posedge clk) begin : check_outputs
        exp_entry_t head;
        if (!reset) begin
            assert (!(commit_valid && flush_valid)) else begin
                $display("Commit and flush were reported in the same cycle at %0t", $time);
                error_count++;
            end
            if (commit_valid) begin
                commit_count++;
                assert (expect_q.size() != 0) else begin
                    $display("Commit at %0t with no outstanding instruction", $time);
                    error_count++;
                end
                if (expect_q.size() != 0) begin
                    head = expect_q.pop_front();
                    assert (head.cause == rob_pkg::CAUSE_NONE) else begin
                        $display("Instruction at pc %h committed instead of flushing", head.pc);
                        error_count++;
                    end
                    assert (commit_pc == head.pc) else begin
                        $display("** Error @ %0t: commit_pc expected %h, got %h",
                                 $time, head.pc, commit_pc);
                        error_count++;
                    end
                    assert (commit_rd == head.rd) else begin
                        $display("** Error @ %0t: commit_rd expected %0d, got %0d",
                                 $time, head.rd, commit_rd);
                        error_count++;
                    end
                    assert (commit_value == head.value) else begin
                        $display("** Error @ %0t: commit_value expected %h, got %h",
                                 $time, head.value, commit_value);
                        error_count++;
                    end
                end
            end
            if (flush_valid) begin
                flush_count++;
                assert (expect_q.size() != 0) else begin
                    $display("Flush at %0t with no outstanding instruction", $time);
                    error_count++;
                end
                if (expect_q.size() != 0) begin
                    head = expect_q[0];
                    assert (flush_pc == head.pc) else begin
                        $display("** Error @ %0t: flush_pc expected %h, got %h",
                                 $time, head.pc, flush_pc);
                        error_count++;
                    end
                    assert (flush_cause == head.cause) else begin
                        $display("** Error @ %0t: flush_cause expected %0d, got %0d",
                                 $time, head.cause, flush_cause);
                        error_count++;
                    end
                end
                // Everything younger is discarded, including an issue taken at the flush edge
                expect_q.delete();
            end
            assert (full == (expect_q.size() == ROB_SIZE)) else begin
                $display("** Error @ %0t: full expected %0b, got %0b",
                         $time, expect_q.size() == ROB_SIZE, full);
                error_count++;
            end
            if (full) begin
                full_cycles++;
            end
            if (issue_valid && !full && !flush_valid) begin
                expect_q.push_back(model_entry(issue_pc, issue_rd, issue_op, issue_a, issue_b));
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin : stimulus
        int issued;
        int drain_cycles;
        logic [31:0] r;
        reset       = 1'b1;
        issue_valid = 1'b0;
        issue_pc    = 32'h0;
        issue_rd    = 5'h0;
        issue_op    = rob_pkg::OP_ADD;
        issue_a     = 32'h0;
        issue_b     = 32'h0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Random phase, about six issues in ten cycles
        issued = 0;
        while (issued < NUM_RANDOM) begin
            @(negedge clk);
            r = next_random();
            if (!full && !flush_valid && (r[31:16] % 10) < 6) begin
                drive_random_issue();
                issued++;
            end else begin
                issue_valid = 1'b0;
            end
        end

        // Burst phase issues whenever allowed
        issued = 0;
        while (issued < NUM_BURST) begin
            @(negedge clk);
            if (!full && !flush_valid) begin
                drive_random_issue();
                issued++;
            end else begin
                issue_valid = 1'b0;
            end
        end
        @(negedge clk);
        issue_valid = 1'b0;

        // Drain, bounded by the slowest path through a full buffer
        drain_cycles = 0;
        while (expect_q.size() != 0 && drain_cycles < DRAIN_LIMIT) begin
            @(negedge clk);
            drain_cycles++;
        end
        repeat (ROB_SIZE + NUM_LANES + LANE_BASE_LATENCY) @(negedge clk);
        assert (full == 1'b0) else begin
            $display("** Error @ %0t: full expected 0, got %0b", $time, full);
            error_count++;
        end
        assert (expect_q.size() == 0) else begin
            $display("Instructions left outstanding after drain: %0d", expect_q.size());
            error_count++;
        end
        assert (full_cycles != 0) else begin
            $display("The buffer never became full during the burst");
            error_count++;
        end
        assert (flush_count != 0 && commit_count != 0) else begin
            $display("Run did not exercise both commits and flushes");
            error_count++;
        end

        $display("Errors: %0d, commits: %0d, flushes: %0d, full cycles: %0d",
                 error_count, commit_count, flush_count, full_cycles);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
rtl/rob_pkg.sv
rtl/lane_req_if.sv
rtl/complete_if.sv
rtl/dispatch_unit.sv
rtl/exec_lane.sv
rtl/reorder_buffer.sv
rtl/rob_subsystem.sv
verif/tb_rob_subsystem.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert -Wno-fatal
TOP       := tb_rob_subsystem
FILELIST  := sim.f

SIM_DIR   := obj_dir
SIM_BIN   := $(SIM_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))
LOG       := sim.log

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(SIM_DIR) -o V$(TOP)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(SIM_DIR) $(LOG)
